/* rtl/zx_pkg.sv */
package zx_pkg;

	// ============================================================
	// Bus and memory widths
	// ============================================================

	// Z80 address bus
	localparam int CPU_AW = 16;

	// Paged RAM address, bit 17 selects the ROM region
	localparam int PHYS_AW = 18;

	// Offset inside one 16 KB bank
	localparam int BANK_AW = 14;

	localparam int DATA_W = 8;

	// Bit of the physical address that marks ROM pages
	localparam int PHYS_ROM_BIT = PHYS_AW - 1;

	// Words in the paged RAM
	localparam int RAM_DEPTH = 1 << PHYS_AW;

	// ============================================================
	// Machine models
	// ============================================================

	typedef enum logic [1:0] {
		MODEL_128   = 2'd0,
		MODEL_48    = 2'd1,
		MODEL_PLUS3 = 2'd2
	} model_t;

	// ============================================================
	// Port decode and paging register bits
	// ============================================================

	// Upper nibble of the +3 1FFD port
	localparam logic [3:0] PORT_1FFD_HI = 4'b0001;

	localparam int PORT_7FFD_BIT_LOCK   = 5;
	localparam int PORT_7FFD_BIT_ROM    = 4;
	localparam int PORT_7FFD_BIT_SCREEN = 3;

	localparam int PORT_1FFD_BIT_SPECIAL = 0;
	localparam int PORT_1FFD_BIT_ROMHI   = 2;

	// Fixed banks of slots 1 and 2 in normal mode
	localparam logic [2:0] BANK_SCREEN = 3'd5;
	localparam logic [2:0] BANK_MID    = 3'd2;

endpackage

/* rtl/port_regs.sv */
module port_regs import zx_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  model_t            cfg_model,
	input  logic [CPU_AW-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              cpu_iorq,
	input  logic              cpu_wr,
	input  logic              cpu_m1,
	output model_t            model,
	output logic [DATA_W-1:0] page_7ffd,
	output logic [DATA_W-1:0] page_1ffd,
	output logic              paging_locked,
	output logic [2:0]        border_color,
	output logic              ear_out,
	output logic              mic_out
);

	// ============================================================
	// I/O write strobe and edge
	// ============================================================

	logic io_wr;
	logic io_wr_d;
	logic io_wr_edge;

	// An interrupt acknowledge also raises iorq, but with m1
	assign io_wr = cpu_iorq & cpu_wr & ~cpu_m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
		end
	end

	// Only the first clock of a write counts
	assign io_wr_edge = io_wr & ~io_wr_d;

	// ============================================================
	// Port decode
	// ============================================================

	logic is_plus3;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_fe;

	assign is_plus3 = (model == MODEL_PLUS3);

	// Partial decode, A14 only matters on the +3
	assign sel_7ffd = ~cpu_addr[15] & ~cpu_addr[1] & (cpu_addr[14] | ~is_plus3);

	assign sel_1ffd = is_plus3 & (cpu_addr[15:12] == PORT_1FFD_HI) & ~cpu_addr[1];

	// ULA answers on every even port
	assign sel_fe = ~cpu_addr[0];

	// 48K has no paging at all; otherwise the lock bit sticks until reset
	assign paging_locked = (model == MODEL_48) | page_7ffd[PORT_7FFD_BIT_LOCK];

	// ============================================================
	// Paging registers and model
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model     <= cfg_model;
			page_7ffd <= '0;
			page_1ffd <= '0;
		end else if (io_wr_edge & ~paging_locked) begin
			if (sel_7ffd) begin
				page_7ffd <= cpu_dout;
			end else if (sel_1ffd) begin
				page_1ffd <= cpu_dout;
			end
		end
	end

	// ============================================================
	// ULA port FE
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr_edge & sel_fe) begin
			border_color <= cpu_dout[2:0];
			// EAR on bit 4, MIC on bit 3
			ear_out      <= cpu_dout[4];
			mic_out      <= cpu_dout[3];
		end
	end

endmodule

/* rtl/mem_map.sv */
module mem_map import zx_pkg::*; (
	input  model_t             model,
	input  logic [DATA_W-1:0]  page_7ffd,
	input  logic [DATA_W-1:0]  page_1ffd,
	input  logic [CPU_AW-1:0]  cpu_addr,
	input  logic [DATA_W-1:0]  cpu_dout,
	input  logic               cpu_mreq,
	input  logic               cpu_wr,
	input  logic               load_wr,
	input  logic [PHYS_AW-1:0] load_addr,
	input  logic [DATA_W-1:0]  load_data,
	output logic [PHYS_AW-1:0] phys_addr,
	output logic               ram_wr,
	output logic [DATA_W-1:0]  ram_wdata
);

	logic [1:0]         slot;
	logic [BANK_AW-1:0] offset;
	logic [1:0]         rom_page;
	logic               special;
	logic [1:0]         special_cfg;
	logic [2:0]         bank;
	logic               to_rom;
	logic [PHYS_AW-1:0] cpu_phys;
	logic               cpu_we;

	assign slot   = cpu_addr[CPU_AW-1 -: 2];
	assign offset = cpu_addr[BANK_AW-1:0];

	// ============================================================
	// ROM page select
	// ============================================================

	always_comb begin
		case (model)
			MODEL_48:    rom_page = 2'd1;
			MODEL_PLUS3: rom_page = {page_1ffd[PORT_1FFD_BIT_ROMHI],
				page_7ffd[PORT_7FFD_BIT_ROM]};
			default:     rom_page = {1'b0, page_7ffd[PORT_7FFD_BIT_ROM]};
		endcase
	end

	// ============================================================
	// Slot to bank
	// ============================================================

	// All-RAM layouts exist only on the +3
	assign special     = (model == MODEL_PLUS3) & page_1ffd[PORT_1FFD_BIT_SPECIAL];
	assign special_cfg = page_1ffd[2:1];

	always_comb begin
		to_rom = 1'b0;
		bank   = 3'd0;
		if (special) begin
			case ({special_cfg, slot})
				4'b00_00: bank = 3'd0;
				4'b00_01: bank = 3'd1;
				4'b00_10: bank = 3'd2;
				4'b00_11: bank = 3'd3;
				4'b01_00: bank = 3'd4;
				4'b01_01: bank = 3'd5;
				4'b01_10: bank = 3'd6;
				4'b01_11: bank = 3'd7;
				4'b10_00: bank = 3'd4;
				4'b10_01: bank = 3'd5;
				4'b10_10: bank = 3'd6;
				4'b10_11: bank = 3'd3;
				4'b11_00: bank = 3'd4;
				4'b11_01: bank = 3'd7;
				4'b11_10: bank = 3'd6;
				default:  bank = 3'd3;
			endcase
		end else begin
			case (slot)
				2'd0: to_rom = 1'b1;
				2'd1: bank = BANK_SCREEN;
				2'd2: bank = BANK_MID;
				default: bank = page_7ffd[2:0];
			endcase
		end
	end

	// ROM pages sit above all RAM banks
	assign cpu_phys = to_rom ? {1'b1, 1'b0, rom_page, offset} : {1'b0, bank, offset};

	// ROM is read only for the CPU
	assign cpu_we = cpu_mreq & cpu_wr & ~cpu_phys[PHYS_ROM_BIT];

	// ============================================================
	// Loader has priority over the CPU
	// ============================================================

	assign phys_addr = load_wr ? load_addr : cpu_phys;
	assign ram_wr    = load_wr | cpu_we;
	assign ram_wdata = load_wr ? load_data : cpu_dout;

endmodule

/* rtl/paged_ram.sv */
module paged_ram import zx_pkg::*; (
	input  logic               clk_sys,
	input  logic [PHYS_AW-1:0] phys_addr,
	input  logic               ram_wr,
	input  logic [DATA_W-1:0]  ram_wdata,
	output logic [DATA_W-1:0]  ram_dout
);

	// ============================================================
	// Physical memory
	// ============================================================

	// Eight RAM banks in the lower half, four ROM pages above
	logic [DATA_W-1:0] mem [RAM_DEPTH];

	always_ff @(posedge clk_sys) begin
		if (ram_wr) begin
			mem[phys_addr] <= ram_wdata;
		end
	end

	// Registered read, old data on a write to the same address
	always_ff @(posedge clk_sys) begin
		ram_dout <= mem[phys_addr];
	end

endmodule

/* rtl/zx_memory_top.sv */
module zx_memory_top import zx_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  model_t             cfg_model,
	input  logic [CPU_AW-1:0]  cpu_addr,
	input  logic [DATA_W-1:0]  cpu_dout,
	input  logic               cpu_mreq,
	input  logic               cpu_iorq,
	// Unused, a read needs no strobe since the RAM read is free running
	input  logic               cpu_rd,
	input  logic               cpu_wr,
	input  logic               cpu_m1,
	input  logic               load_wr,
	input  logic [PHYS_AW-1:0] load_addr,
	input  logic [DATA_W-1:0]  load_data,
	output logic [DATA_W-1:0]  ram_dout,
	output logic [2:0]         border_color,
	output logic               ear_out,
	output logic               mic_out,
	output logic               screen_page
);

	model_t             model;
	logic [DATA_W-1:0]  page_7ffd;
	logic [DATA_W-1:0]  page_1ffd;
	logic               paging_locked;
	logic [PHYS_AW-1:0] phys_addr;
	logic               ram_wr;
	logic [DATA_W-1:0]  ram_wdata;

	// Video picks bank 5 or bank 7 from this
	assign screen_page = page_7ffd[PORT_7FFD_BIT_SCREEN];

	// ============================================================
	// Port registers
	// ============================================================

	port_regs port_regs_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cfg_model     (cfg_model),
		.cpu_addr      (cpu_addr),
		.cpu_dout      (cpu_dout),
		.cpu_iorq      (cpu_iorq),
		.cpu_wr        (cpu_wr),
		.cpu_m1        (cpu_m1),
		.model         (model),
		.page_7ffd     (page_7ffd),
		.page_1ffd     (page_1ffd),
		.paging_locked (paging_locked),
		.border_color  (border_color),
		.ear_out       (ear_out),
		.mic_out       (mic_out)
	);

	// ============================================================
	// Address translation and memory
	// ============================================================

	mem_map mem_map_inst (
		.model     (model),
		.page_7ffd (page_7ffd),
		.page_1ffd (page_1ffd),
		.cpu_addr  (cpu_addr),
		.cpu_dout  (cpu_dout),
		.cpu_mreq  (cpu_mreq),
		.cpu_wr    (cpu_wr),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.phys_addr (phys_addr),
		.ram_wr    (ram_wr),
		.ram_wdata (ram_wdata)
	);

	paged_ram paged_ram_inst (
		.clk_sys   (clk_sys),
		.phys_addr (phys_addr),
		.ram_wr    (ram_wr),
		.ram_wdata (ram_wdata),
		.ram_dout  (ram_dout)
	);

endmodule

/* sim/zx_memory_checker.sv */
module zx_memory_checker import zx_pkg::*; (
	input logic              clk_sys,
	input logic              reset,
	input model_t            model,
	input logic [DATA_W-1:0] page_7ffd,
	input logic              paging_locked,
	input logic [2:0]        border_color,
	input logic              io_wr_edge
);

	// ============================================================
	// Paging lock
	// ============================================================

	// Only the 48K comes out of reset locked
	property unlocked_after_reset;
		@(posedge clk_sys) $past(reset) && (model != MODEL_48) |-> !paging_locked;
	endproperty

	// A locked 7FFD register holds until the next reset
	property page_held_while_locked;
		@(posedge clk_sys) !$past(reset) && $past(paging_locked) |-> $stable(page_7ffd);
	endproperty

	// ============================================================
	// ULA border
	// ============================================================

	property border_follows_io_write;
		@(posedge clk_sys) !$stable(border_color) |-> $past(io_wr_edge) || $past(reset);
	endproperty

	assert property (unlocked_after_reset)
		else $error("paging locked after reset on a model with paging");

	assert property (page_held_while_locked)
		else $error("page_7ffd changed while paging was locked");

	assert property (border_follows_io_write)
		else $error("border_color changed without an I/O write");

endmodule

bind port_regs zx_memory_checker zx_memory_checker_inst (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.model         (model),
	.page_7ffd     (page_7ffd),
	.paging_locked (paging_locked),
	.border_color  (border_color),
	.io_wr_edge    (io_wr_edge)
);

/* sim/zx_memory_tb.sv */
module zx_memory_tb import zx_pkg::*; ();

	typedef enum logic [2:0] {
		OP_RESET,
		OP_LOAD,
		OP_IOWR,
		OP_MEMWR,
		OP_MEMRD,
		OP_CHECK
	} op_t;

	typedef struct packed {
		op_t                op;
		logic [PHYS_AW-1:0] addr;
		logic [DATA_W-1:0]  data;
		logic [DATA_W-1:0]  expected;
	} entry_t;

	localparam logic [CPU_AW-1:0]  PORT_7FFD = 16'h7FFD;
	localparam logic [CPU_AW-1:0]  PORT_1FFD = 16'h1FFD;
	localparam logic [CPU_AW-1:0]  PORT_FE   = 16'h00FE;
	localparam logic [BANK_AW-1:0] OFS       = 14'h0123;

	logic               clk_sys;
	logic               reset;
	model_t             cfg_model;
	logic [CPU_AW-1:0]  cpu_addr;
	logic [DATA_W-1:0]  cpu_dout;
	logic               cpu_mreq;
	logic               cpu_iorq;
	logic               cpu_rd;
	logic               cpu_wr;
	logic               cpu_m1;
	logic               load_wr;
	logic [PHYS_AW-1:0] load_addr;
	logic [DATA_W-1:0]  load_data;
	logic [DATA_W-1:0]  ram_dout;
	logic [2:0]         border_color;
	logic               ear_out;
	logic               mic_out;
	logic               screen_page;

	entry_t            stim_q[$];
	// Expected physical memory built up along with the table
	logic [DATA_W-1:0] exp_mem [int];
	logic [31:0]       lcg_state = 32'd12;
	int                cycle_count = 0;
	int                cycle_limit = 0;

	zx_memory_top zx_memory_top_inst (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: stimulus table not finished after %0d cycles", cycle_limit);
			$display("Test failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// ============================================================
	// Reference helpers
	// ============================================================

	function automatic logic [DATA_W-1:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	function automatic logic [PHYS_AW-1:0] bank_phys(input logic [2:0] bank,
			input logic [BANK_AW-1:0] ofs);
		return {1'b0, bank, ofs};
	endfunction

	function automatic logic [PHYS_AW-1:0] rom_phys(input logic [1:0] page,
			input logic [BANK_AW-1:0] ofs);
		return {2'b10, page, ofs};
	endfunction

	function automatic logic [CPU_AW-1:0] slot_addr(input logic [1:0] slot,
			input logic [BANK_AW-1:0] ofs);
		return {slot, ofs};
	endfunction

	// +3 all-RAM layouts as one octal digit per slot with slot 0 lowest
	function automatic logic [2:0] special_bank(input logic [1:0] cfg, input logic [1:0] slot);
		logic [11:0] list;
		case (cfg)
			2'd0:    list = 12'o3210;
			2'd1:    list = 12'o7654;
			2'd2:    list = 12'o3654;
			default: list = 12'o3674;
		endcase
		return list[slot*3 +: 3];
	endfunction

	// ============================================================
	// Table building
	// ============================================================

	task automatic add_entry(input op_t op, input logic [PHYS_AW-1:0] addr,
			input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] expected);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.data     = data;
		e.expected = expected;
		stim_q.push_back(e);
	endtask

	task automatic push_reset(input model_t m);
		add_entry(OP_RESET, '0, {6'd0, m}, '0);
	endtask

	task automatic push_load(input logic [PHYS_AW-1:0] phys, input logic [DATA_W-1:0] data);
		add_entry(OP_LOAD, phys, data, '0);
		exp_mem[int'(phys)] = data;
	endtask

	task automatic push_io(input logic [CPU_AW-1:0] port, input logic [DATA_W-1:0] data);
		add_entry(OP_IOWR, {2'b00, port}, data, '0);
	endtask

	task automatic push_write(input logic [CPU_AW-1:0] addr, input logic [PHYS_AW-1:0] phys,
			input logic [DATA_W-1:0] data);
		add_entry(OP_MEMWR, {2'b00, addr}, data, '0);
		// ROM pages keep their contents
		if (!phys[PHYS_AW-1]) begin
			exp_mem[int'(phys)] = data;
		end
	endtask

	task automatic push_read(input logic [CPU_AW-1:0] addr, input logic [PHYS_AW-1:0] phys);
		add_entry(OP_MEMRD, {2'b00, addr}, '0, exp_mem[int'(phys)]);
	endtask

	task automatic push_outputs(input logic screen, input logic ear, input logic mic,
			input logic [2:0] border);
		add_entry(OP_CHECK, '0, '0, {2'b00, screen, ear, mic, border});
	endtask

	task automatic build_table();
		logic [DATA_W-1:0] d;
		int p;
		int b;
		int c;
		int s;
		// ROM pages on 128K and an ignored CPU write to ROM
		push_reset(MODEL_128);
		push_outputs(1'b0, 1'b0, 1'b0, 3'd0);
		for (p = 0; p < 4; p++) begin
			d = next_rand();
			push_load(rom_phys(p[1:0], OFS), {d[7:2], p[1:0]});
		end
		push_read(slot_addr(2'd0, OFS), rom_phys(2'd0, OFS));
		push_io(PORT_7FFD, 8'h10);
		push_read(slot_addr(2'd0, OFS), rom_phys(2'd1, OFS));
		push_write(slot_addr(2'd0, OFS), rom_phys(2'd1, OFS),
			~exp_mem[int'(rom_phys(2'd1, OFS))]);
		push_read(slot_addr(2'd0, OFS), rom_phys(2'd1, OFS));
		// Bank select through slot 3
		for (b = 0; b < 8; b++) begin
			d = next_rand();
			push_io(PORT_7FFD, {5'd0, b[2:0]});
			push_write(slot_addr(2'd3, OFS), bank_phys(b[2:0], OFS), {d[4:0], b[2:0]});
		end
		push_read(slot_addr(2'd1, OFS), bank_phys(3'd5, OFS));
		push_read(slot_addr(2'd2, OFS), bank_phys(3'd2, OFS));
		for (b = 7; b >= 0; b--) begin
			push_io(PORT_7FFD, {5'd0, b[2:0]});
			push_read(slot_addr(2'd3, OFS), bank_phys(b[2:0], OFS));
		end
		// Lock bit with screen page 1 and bank 3
		push_io(PORT_7FFD, 8'h2B);
		push_outputs(1'b1, 1'b0, 1'b0, 3'd0);
		push_io(PORT_7FFD, 8'h06);
		push_read(slot_addr(2'd3, OFS), bank_phys(3'd3, OFS));
		push_outputs(1'b1, 1'b0, 1'b0, 3'd0);
		push_reset(MODEL_128);
		push_outputs(1'b0, 1'b0, 1'b0, 3'd0);
		push_read(slot_addr(2'd3, OFS), bank_phys(3'd0, OFS));
		// +3 ROM page from 1FFD bit 2 and 7FFD bit 4
		push_reset(MODEL_PLUS3);
		push_io(PORT_1FFD, 8'h04);
		push_read(slot_addr(2'd0, OFS), rom_phys(2'd2, OFS));
		push_io(PORT_7FFD, 8'h10);
		push_read(slot_addr(2'd0, OFS), rom_phys(2'd3, OFS));
		push_io(PORT_1FFD, 8'h00);
		push_read(slot_addr(2'd0, OFS), rom_phys(2'd1, OFS));
		// Read back what the previous layout left and then refill
		for (c = 0; c < 4; c++) begin
			push_io(PORT_1FFD, {5'd0, c[1:0], 1'b1});
			for (s = 0; s < 4; s++) begin
				push_read(slot_addr(s[1:0], OFS),
					bank_phys(special_bank(c[1:0], s[1:0]), OFS));
			end
			for (s = 0; s < 4; s++) begin
				d = next_rand();
				push_write(slot_addr(s[1:0], OFS),
					bank_phys(special_bank(c[1:0], s[1:0]), OFS), d);
			end
		end
		push_io(PORT_1FFD, 8'h00);
		push_read(slot_addr(2'd3, OFS), bank_phys(3'd0, OFS));
		push_read(slot_addr(2'd1, OFS), bank_phys(3'd5, OFS));
		// 48K ignores 7FFD
		push_reset(MODEL_48);
		push_read(slot_addr(2'd0, OFS), rom_phys(2'd1, OFS));
		push_io(PORT_7FFD, 8'h1F);
		push_read(slot_addr(2'd0, OFS), rom_phys(2'd1, OFS));
		push_read(slot_addr(2'd3, OFS), bank_phys(3'd0, OFS));
		push_outputs(1'b0, 1'b0, 1'b0, 3'd0);
		// ULA port with border in bits 2..0, MIC in bit 3 and EAR in bit 4
		push_io(PORT_FE, 8'h1D);
		push_outputs(1'b0, 1'b1, 1'b1, 3'd5);
		push_io(PORT_FE, 8'h12);
		push_outputs(1'b0, 1'b1, 1'b0, 3'd2);
	endtask

	// ============================================================
	// Checking and stimulus
	// ============================================================

	task automatic check_value(input logic [DATA_W-1:0] actual,
			input logic [DATA_W-1:0] expected, input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s, got %02h, expected %02h",
				$time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Called on a falling edge with strobes lasting one cycle
	task automatic apply_entry(input entry_t e);
		case (e.op)
			OP_RESET: begin
				cfg_model = model_t'(e.data[1:0]);
				reset     = 1'b1;
				repeat (5) @(negedge clk_sys);
				reset     = 1'b0;
			end
			OP_LOAD: begin
				load_addr = e.addr;
				load_data = e.data;
				load_wr   = 1'b1;
				@(negedge clk_sys);
				load_wr   = 1'b0;
			end
			OP_IOWR: begin
				cpu_addr = e.addr[CPU_AW-1:0];
				cpu_dout = e.data;
				cpu_iorq = 1'b1;
				cpu_wr   = 1'b1;
				@(negedge clk_sys);
				cpu_iorq = 1'b0;
				cpu_wr   = 1'b0;
			end
			OP_MEMWR: begin
				cpu_addr = e.addr[CPU_AW-1:0];
				cpu_dout = e.data;
				cpu_mreq = 1'b1;
				cpu_wr   = 1'b1;
				@(negedge clk_sys);
				cpu_mreq = 1'b0;
				cpu_wr   = 1'b0;
			end
			OP_MEMRD: begin
				cpu_addr = e.addr[CPU_AW-1:0];
				cpu_mreq = 1'b1;
				cpu_rd   = 1'b1;
				// Data registered at the rising edge in between
				@(negedge clk_sys);
				check_value(ram_dout, e.expected,
					$sformatf("read of %04h", e.addr[CPU_AW-1:0]));
				cpu_mreq = 1'b0;
				cpu_rd   = 1'b0;
			end
			OP_CHECK: begin
				check_value({2'b00, screen_page, ear_out, mic_out, border_color},
					e.expected, "screen page, EAR, MIC and border outputs");
			end
			default: begin
				$display("Unknown operation %0d in the stimulus table", e.op);
				$display("Test failed");
				$fatal(1, "Bad stimulus table");
			end
		endcase
	endtask

	initial begin
		reset     = 1'b1;
		cfg_model = MODEL_128;
		cpu_addr  = '0;
		cpu_dout  = '0;
		cpu_mreq  = 1'b0;
		cpu_iorq  = 1'b0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		cpu_m1    = 1'b0;
		load_wr   = 1'b0;
		load_addr = '0;
		load_data = '0;
		build_table();
		cycle_limit = stim_q.size() * 4 + 100;
		foreach (stim_q[i]) begin
			@(negedge clk_sys);
			apply_entry(stim_q[i]);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* tb.f */
rtl/zx_pkg.sv
rtl/port_regs.sv
rtl/mem_map.sv
rtl/paged_ram.sv
rtl/zx_memory_top.sv
sim/zx_memory_checker.sv
sim/zx_memory_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory paging testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=zx_memory_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
	-f tb.f \
	--top-module zx_memory_tb \
	--Mdir "$OBJ_DIR" \
	-o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG_FILE"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
